// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

	// operation presented to the multiply/divide unit, held while stalled
	typedef enum logic [2:0] {
		op_none  = 3'd0,
		op_mult  = 3'd1,
		op_multu = 3'd2,
		op_div   = 3'd3,
		op_divu  = 3'd4,
		op_mthi  = 3'd5,
		op_mtlo  = 3'd6
	} muldiv_op_t;

	// divide sequencer states
	typedef enum logic [1:0] {
		div_idle = 2'd0,
		div_busy = 2'd1,
		div_done = 2'd2
	} div_state_t;

endpackage

// ==== logic/muldiv_ctrl.sv ====
module muldiv_ctrl
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       flush,
	input  muldiv_op_t op,
	input  logic       last_step,
	output logic       start,
	output logic       step,
	output logic       div_done,
	output logic       stall_req
);

	div_state_t state;
	div_state_t state_next;
	logic       is_div;

	assign is_div = (op == op_div) || (op == op_divu);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpu_pkg::div_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			cpu_pkg::div_idle: begin
				if (is_div) begin
					state_next = cpu_pkg::div_busy;
				end
			end
			cpu_pkg::div_busy: begin
				if (last_step) begin
					state_next = cpu_pkg::div_done;
				end
			end
			cpu_pkg::div_done: begin
				state_next = cpu_pkg::div_idle;
			end
			default: begin
				state_next = cpu_pkg::div_idle;
			end
		endcase
		// flush wins from any state
		if (flush) begin
			state_next = cpu_pkg::div_idle;
		end
	end

	always_comb begin
		start     = 1'b0;
		step      = 1'b0;
		div_done  = 1'b0;
		stall_req = 1'b0;
		case (state)
			cpu_pkg::div_idle: begin
				// hold the pipeline from the first divide cycle
				stall_req = is_div;
				start     = is_div && !flush;
			end
			cpu_pkg::div_busy: begin
				step      = 1'b1;
				stall_req = 1'b1;
			end
			cpu_pkg::div_done: begin
				// pipeline advances here, result goes to HI/LO
				div_done = !flush;
			end
			default: begin
				stall_req = 1'b0;
			end
		endcase
	end

endmodule

// ==== logic/iter_counter.sv ====
module iter_counter #(
	parameter int width = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic count_clear,
	input  logic step,
	output logic last_step
);

	localparam int count_w = $clog2(width);

	logic [count_w-1:0] count;

	// one step per quotient bit, counting down to zero
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (count_clear) begin
			count <= count_w'(width - 1);
		end else if (step && (count != '0)) begin
			count <= count - 1'b1;
		end
	end

	assign last_step = step && (count == '0);

endmodule

// ==== logic/div_datapath.sv ====
module div_datapath
	import cpu_pkg::*;
#(
	parameter int width = 32
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  logic             step,
	input  muldiv_op_t       op,
	input  logic [width-1:0] rs_data,
	input  logic [width-1:0] rt_data,
	output logic [width-1:0] quotient,
	output logic [width-1:0] remainder
);

	logic             op_signed;
	logic [width-1:0] rs_mag;
	logic [width-1:0] rt_mag;

	// sign information captured at start
	logic signed_op;
	logic dividend_neg;
	logic quotient_neg;

	// dividend bits shift out the top while quotient bits shift in below
	logic [width-1:0] dvd_shift;
	logic [width-1:0] dsr_mag;
	logic [width-1:0] part_rem;

	logic [width:0] trial;
	logic [width:0] diff;
	logic           q_bit;

	assign op_signed = (op == op_div);

	// most negative value keeps its pattern, which is the right unsigned magnitude
	assign rs_mag = (op_signed && rs_data[width-1]) ? -rs_data : rs_data;
	assign rt_mag = (op_signed && rt_data[width-1]) ? -rt_data : rt_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			signed_op    <= 1'b0;
			dividend_neg <= 1'b0;
			quotient_neg <= 1'b0;
		end else if (start) begin
			signed_op    <= op_signed;
			dividend_neg <= rs_data[width-1];
			quotient_neg <= rs_data[width-1] ^ rt_data[width-1];
		end
	end

	// restoring step
	assign trial = {part_rem, dvd_shift[width-1]};
	assign diff  = trial - {1'b0, dsr_mag};
	assign q_bit = !diff[width];

	always_ff @(posedge clk) begin
		if (start) begin
			dvd_shift <= rs_mag;
			dsr_mag   <= rt_mag;
			part_rem  <= '0;
		end else if (step) begin
			// zero divisor always subtracts, giving all ones and the full dividend
			if (q_bit) begin
				part_rem <= diff[width-1:0];
			end else begin
				part_rem <= trial[width-1:0];
			end
			dvd_shift <= {dvd_shift[width-2:0], q_bit};
		end
	end

	// sign fix, remainder follows the dividend
	always_comb begin
		if (signed_op && quotient_neg) begin
			quotient = -dvd_shift;
		end else begin
			quotient = dvd_shift;
		end
		if (signed_op && dividend_neg) begin
			remainder = -part_rem;
		end else begin
			remainder = part_rem;
		end
	end

endmodule

// ==== logic/hilo_unit.sv ====
module hilo_unit
	import cpu_pkg::*;
#(
	parameter int width = 32
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,
	input  muldiv_op_t       op,
	input  logic [width-1:0] rs_data,
	input  logic [width-1:0] rt_data,
	input  logic             div_done,
	input  logic [width-1:0] quotient,
	input  logic [width-1:0] remainder,
	output logic [width-1:0] hi,
	output logic [width-1:0] lo
);

	logic [2*width-1:0] rs_ext;
	logic [2*width-1:0] rt_ext;
	logic [2*width-1:0] product;

	// extend to double width so one multiplier covers mult and multu
	always_comb begin
		if (op == op_mult) begin
			rs_ext = {{width{rs_data[width-1]}}, rs_data};
			rt_ext = {{width{rt_data[width-1]}}, rt_data};
		end else begin
			rs_ext = {{width{1'b0}}, rs_data};
			rt_ext = {{width{1'b0}}, rt_data};
		end
	end

	// low 2*width bits are exact in both cases
	assign product = rs_ext * rt_ext;

	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= '0;
			lo <= '0;
		end else if (div_done) begin
			hi <= remainder;
			lo <= quotient;
		end else if (!flush) begin
			case (op)
				op_mult, op_multu: begin
					hi <= product[2*width-1:width];
					lo <= product[width-1:0];
				end
				op_mthi: begin
					hi <= rs_data;
				end
				op_mtlo: begin
					lo <= rs_data;
				end
				default: begin
					// divides write through div_done
					hi <= hi;
					lo <= lo;
				end
			endcase
		end
	end

endmodule

// ==== logic/ex_muldiv.sv ====
module ex_muldiv
	import cpu_pkg::*;
#(
	parameter int width = 32
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,
	input  muldiv_op_t       op,
	input  logic [width-1:0] rs_data,
	input  logic [width-1:0] rt_data,
	output logic [width-1:0] hi,
	output logic [width-1:0] lo,
	output logic             stall_req
);

	logic             start;
	logic             step;
	logic             last_step;
	logic             div_done;
	logic [width-1:0] quotient;
	logic [width-1:0] remainder;

	// divide sequencing
	muldiv_ctrl muldiv_ctrl_instance(
		.clk,
		.reset,
		.flush,
		.op,
		.last_step,
		.start,
		.step,
		.div_done,
		.stall_req
	);

	iter_counter #(
		.width(width)
	) iter_counter_instance (
		.clk,
		.reset,
		.count_clear(start),
		.step,
		.last_step
	);

	div_datapath #(
		.width(width)
	) div_datapath_instance (
		.clk,
		.reset,
		.start,
		.step,
		.op,
		.rs_data,
		.rt_data,
		.quotient,
		.remainder
	);

	// HI/LO registers
	hilo_unit #(
		.width(width)
	) hilo_instance (
		.clk,
		.reset,
		.flush,
		.op,
		.rs_data,
		.rt_data,
		.div_done,
		.quotient,
		.remainder,
		.hi,
		.lo
	);

endmodule

// ==== verif/tb_ex_muldiv.sv ====
module tb_ex_muldiv
	import cpu_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int width = 32;
	localparam int stall_cycles = width + 1;
	localparam int stall_limit = width + 10;
	localparam int n_rand_mult = 20;
	localparam int n_rand_div = 12;
	// random and corner divides, the flushed one and the back-to-back pair
	localparam int n_divides = n_rand_div + 6 + 3;
	localparam int budget_cycles = 7 + 4 * n_rand_mult + 4 + n_divides * (width + 4) + 10;
	localparam int watchdog_ns = budget_cycles * 8 + 500;

	logic             clk;
	logic             reset;
	logic             flush;
	muldiv_op_t       op;
	logic [width-1:0] rs_data;
	logic [width-1:0] rt_data;
	logic [width-1:0] hi;
	logic [width-1:0] lo;
	logic             stall_req;

	// HI/LO model
	logic [width-1:0] exp_hi;
	logic [width-1:0] exp_lo;
	int               errors;
	integer           seed;

	ex_muldiv #(
		.width(width)
	) UUT (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.op(op),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.hi(hi),
		.lo(lo),
		.stall_req(stall_req)
	);

	always #4 clk = ~clk;

	initial begin
		#(watchdog_ns);
		$display("watchdog: tests did not finish within %0d ns", watchdog_ns);
		$display("Verification failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [width-1:0] expected,
			input logic [width-1:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h (divider state %s)", name, expected,
				actual, UUT.muldiv_ctrl_instance.state.name());
		end
	endtask

	// drive on the falling edge, then settle before sampling
	task automatic present_op(input muldiv_op_t o, input logic [width-1:0] a,
			input logic [width-1:0] b, input logic f);
		@(negedge clk);
		op = o;
		rs_data = a;
		rt_data = b;
		flush = f;
		#2;
	endtask

	function automatic logic [2*width-1:0] wide_product(input logic is_signed,
			input logic [width-1:0] a, input logic [width-1:0] b);
		logic [2*width-1:0] p;
		if (is_signed) begin
			p = $signed(a) * $signed(b);
		end else begin
			p = a * b;
		end
		return p;
	endfunction

	task automatic model_divide(input logic is_signed, input logic [width-1:0] a,
			input logic [width-1:0] b, output logic [width-1:0] q, output logic [width-1:0] r);
		logic [width-1:0] a_mag;
		logic [width-1:0] b_mag;
		logic [width-1:0] q_mag;
		logic [width-1:0] r_mag;
		a_mag = (is_signed && a[width-1]) ? -a : a;
		b_mag = (is_signed && b[width-1]) ? -b : b;
		if (b_mag == '0) begin
			q_mag = '1;
			r_mag = a_mag;
		end else begin
			q_mag = a_mag / b_mag;
			r_mag = a_mag % b_mag;
		end
		q = (is_signed && (a[width-1] ^ b[width-1])) ? -q_mag : q_mag;
		r = (is_signed && a[width-1]) ? -r_mag : r_mag;
	endtask

	// counts the stall run, returns in the done cycle
	task automatic wait_divide(input string name);
		int stalled;
		stalled = 0;
		while (stall_req && stalled < stall_limit) begin
			stalled++;
			@(negedge clk);
			#2;
		end
		if (stall_req) begin
			errors++;
			$display("%s: stall_req still high after %0d cycles", name, stall_limit);
		end
		check_value({name, " stall cycles"}, stall_cycles, stalled);
		check_value({name, " hi before write"}, exp_hi, hi);
		check_value({name, " lo before write"}, exp_lo, lo);
	endtask

	task automatic run_divide(input muldiv_op_t o, input logic [width-1:0] a,
			input logic [width-1:0] b, input string name);
		logic [width-1:0] q;
		logic [width-1:0] r;
		model_divide(o == op_div, a, b, q, r);
		present_op(o, a, b, 1'b0);
		wait_divide(name);
		exp_hi = r;
		exp_lo = q;
		present_op(op_none, '0, '0, 1'b0);
		check_value({name, " hi"}, exp_hi, hi);
		check_value({name, " lo"}, exp_lo, lo);
	endtask

	task automatic test_reset();
		present_op(op_none, '0, '0, 1'b0);
		check_value("reset hi", '0, hi);
		check_value("reset lo", '0, lo);
		check_value("reset stall_req", '0, stall_req);
	endtask

	task automatic test_mult();
		logic [width-1:0]   a;
		logic [width-1:0]   b;
		logic [2*width-1:0] p;
		muldiv_op_t         o;
		string              name;
		for (int i = 0; i < 2 * n_rand_mult; i++) begin
			if (i < n_rand_mult) begin
				o = op_mult;
			end else begin
				o = op_multu;
			end
			name = (o == op_mult) ? "mult" : "multu";
			a = $random(seed);
			b = $random(seed);
			p = wide_product(o == op_mult, a, b);
			present_op(o, a, b, 1'b0);
			check_value({name, " stall_req"}, '0, stall_req);
			exp_hi = p[2*width-1:width];
			exp_lo = p[width-1:0];
			present_op(op_none, '0, '0, 1'b0);
			check_value({name, " hi"}, exp_hi, hi);
			check_value({name, " lo"}, exp_lo, lo);
		end
	endtask

	task automatic test_move();
		logic [width-1:0] a;
		a = $random(seed);
		present_op(op_mthi, a, ~a, 1'b0);
		exp_hi = a;
		present_op(op_none, '0, '0, 1'b0);
		check_value("mthi hi", exp_hi, hi);
		check_value("mthi lo", exp_lo, lo);
		a = $random(seed);
		present_op(op_mtlo, a, ~a, 1'b0);
		exp_lo = a;
		present_op(op_none, '0, '0, 1'b0);
		check_value("mtlo hi", exp_hi, hi);
		check_value("mtlo lo", exp_lo, lo);
	endtask

	task automatic test_divide();
		logic [width-1:0] a;
		logic [width-1:0] b;
		run_divide(op_div, -7, 2, "div negative dividend");
		run_divide(op_div, 7, -2, "div negative divisor");
		run_divide(op_div, -7, -2, "div both negative");
		run_divide(op_div, 32'h8000_0000, 32'hffff_ffff, "div most negative by -1");
		run_divide(op_div, -100, 0, "div by zero");
		run_divide(op_divu, 32'hdead_beef, 0, "divu by zero");
		for (int i = 0; i < n_rand_div; i++) begin
			a = $random(seed);
			b = $random(seed);
			b = b >> (i % 16);
			if (i % 2 == 0) begin
				run_divide(op_div, a, b, "div random");
			end else begin
				run_divide(op_divu, a, b, "divu random");
			end
		end
	endtask

	task automatic test_flush();
		logic [width-1:0] a;
		logic [width-1:0] b;
		a = $random(seed);
		b = $random(seed);
		present_op(op_div, a, b, 1'b0);
		repeat (10) @(negedge clk);
		// flush while busy, op still held
		present_op(op_div, a, b, 1'b1);
		check_value("flush divide stall in flush cycle", 1'b1, stall_req);
		present_op(op_none, '0, '0, 1'b0);
		check_value("flush divide stall after flush", '0, stall_req);
		// past the point where the unflushed divide would have written
		repeat (width + 2) present_op(op_none, '0, '0, 1'b0);
		check_value("flush divide hi", exp_hi, hi);
		check_value("flush divide lo", exp_lo, lo);
		present_op(op_mult, a, b, 1'b1);
		present_op(op_none, '0, '0, 1'b0);
		check_value("flush mult hi", exp_hi, hi);
		check_value("flush mult lo", exp_lo, lo);
	endtask

	task automatic test_back_to_back();
		logic [width-1:0] q;
		logic [width-1:0] r;
		model_divide(1'b1, -1000, 7, q, r);
		present_op(op_div, -1000, 7, 1'b0);
		wait_divide("first divide");
		exp_hi = r;
		exp_lo = q;
		model_divide(1'b0, 32'hffff_0000, 13, q, r);
		present_op(op_divu, 32'hffff_0000, 13, 1'b0);
		check_value("first divide hi", exp_hi, hi);
		check_value("first divide lo", exp_lo, lo);
		wait_divide("second divide");
		exp_hi = r;
		exp_lo = q;
		present_op(op_none, '0, '0, 1'b0);
		check_value("second divide hi", exp_hi, hi);
		check_value("second divide lo", exp_lo, lo);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		flush = 1'b0;
		op = op_none;
		rs_data = '0;
		rt_data = '0;
		exp_hi = '0;
		exp_lo = '0;
		errors = 0;
		seed = 13;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		test_reset();
		test_mult();
		test_move();
		test_divide();
		test_flush();
		test_back_to_back();
		$display("tb_ex_muldiv finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
logic/cpu_pkg.sv
logic/muldiv_ctrl.sv
logic/iter_counter.sv
logic/div_datapath.sv
logic/hilo_unit.sv
logic/ex_muldiv.sv
verif/tb_ex_muldiv.sv

// ==== Bender.yml ====
package:
  name: ex_muldiv

sources:
  - logic/cpu_pkg.sv
  - logic/muldiv_ctrl.sv
  - logic/iter_counter.sv
  - logic/div_datapath.sv
  - logic/hilo_unit.sv
  - logic/ex_muldiv.sv
  - target: test
    files:
      - verif/tb_ex_muldiv.sv
